// File: ks_pkg.sv
package ks_pkg;

	localparam int num_voices = 4;  // string voices in the round robin
	localparam int max_delay = 256;  // entries per delay line
	localparam int debounce_cycles = 4;  // stable cycles before a trig change counts

	// audio sample as it travels between blocks
	typedef logic signed [23:0] sample_t;

	// delay length in samples, 8 to 255 in use
	typedef logic [$clog2(max_delay)-1:0] delay_len_t;

	typedef logic [1:0] filt_sel_t;

	localparam filt_sel_t filt_bypass = 2'd0;  // lossless loop
	localparam filt_sel_t filt_avg = 2'd1;  // plain two-tap mean
	localparam filt_sel_t filt_avg15 = 2'd2;  // mean times 15/16
	localparam filt_sel_t filt_avg7 = 2'd3;  // mean times 7/8

	// x^24 + x^23 + x^22 + x^17 + 1, right-shifting form
	localparam logic [23:0] lfsr_taps = 24'he10000;

	// mixer headroom for the full voice sum
	localparam int mix_width = $bits(sample_t) + $clog2(num_voices);
	localparam sample_t sample_max = 24'sh7fffff;
	localparam sample_t sample_min = 24'sh800000;

	typedef enum logic [1:0]
	{
		voice_idle,
		voice_excite,
		voice_ring
	} voice_state_t;

	// one pluck for one voice
	typedef struct packed
	{
		logic fire;
		delay_len_t length;
	} pluck_cmd_t;

endpackage

// File: ks_synth.f
ks_pkg.sv
noise_lfsr.sv
pluck_dispatch.sv
loop_filter.sv
string_voice.sv
voice_mixer.sv
ks_synth.sv
ks_synth_assertions.sv
tb_ks_synth.sv

// File: ks_synth.sv
module ks_synth (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::sample_t seed_val,
	input ks_pkg::filt_sel_t filtsw,
	input logic trig,  // active low button
	input ks_pkg::delay_len_t delay_length,
	output ks_pkg::sample_t qout,
	output logic [ks_pkg::num_voices-1:0] voice_busy
);
	import ks_pkg::*;

	sample_t noise;  // shared excitation
	pluck_cmd_t pluck [num_voices];
	sample_t voice_sample [num_voices];

	noise_lfsr u_noise (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.seed(seed_val),
		.noise(noise)
	);

	pluck_dispatch u_dispatch (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.trig(trig),
		.delay_length(delay_length),
		.pluck(pluck)
	);

	generate
		for (genvar v = 0; v < num_voices; v++)
		begin : gen_voice
			string_voice u_voice (
				.a_clk(a_clk),
				.reset_n(reset_n),
				.cmd(pluck[v]),
				.noise(noise),
				.filt_sel(filtsw),
				.sample(voice_sample[v]),
				.busy(voice_busy[v])
			);
		end
	endgenerate

	voice_mixer u_mixer (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.samples(voice_sample),
		.mix(qout)
	);

endmodule

// File: ks_synth_assertions.sv
module ks_synth_assertions (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::sample_t qout,
	input logic [ks_pkg::num_voices-1:0] voice_busy,
	input ks_pkg::pluck_cmd_t pluck [ks_pkg::num_voices]
);
	import ks_pkg::*;

	logic [num_voices-1:0] fire_bits;
	int unsigned fail_cnt = 0;  // count of failed assertions

	always_comb
	begin
		for (int i = 0; i < num_voices; i++)
			fire_bits[i] = pluck[i].fire;
	end

	// dispatcher addresses one voice at a time
	one_fire: assert property (@(posedge a_clk) disable iff (reset_n) $onehot0(fire_bits))
	else
	begin
		fail_cnt++;
		$error("more than one voice received a pluck fire in the same cycle");
	end

	qout_cleared: assert property (@(posedge a_clk) reset_n |=> (qout == '0))
	else
	begin
		fail_cnt++;
		$error("qout is not zero in the cycle after reset");
	end

	// voices only go back to idle through reset
	generate
		for (genvar v = 0; v < num_voices; v++)
		begin : gen_busy_hold
			busy_hold: assert property (@(posedge a_clk) disable iff (reset_n)
				voice_busy[v] |=> voice_busy[v])
			else
			begin
				fail_cnt++;
				$error("voice %0d dropped busy without a reset", v);
			end
		end
	endgenerate

endmodule

// File: loop_filter.sv
module loop_filter (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::filt_sel_t filt_sel,
	input ks_pkg::sample_t x,
	output ks_pkg::sample_t y
);
	import ks_pkg::*;

	sample_t x_prev;
	logic signed [$bits(sample_t):0] pair_sum;
	sample_t avg;

	// one-sample history, also cleared when the voice restarts
	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			x_prev <= '0;
		else
			x_prev <= x;
	end

	assign pair_sum = x + x_prev;  // one guard bit, no overflow
	assign avg = sample_t'(pair_sum >>> 1);

	// |y| never exceeds the larger input, so the loop cannot grow
	always_comb
	begin
		case (filt_sel)
			filt_bypass:
				y = x;
			filt_avg:
				y = avg;
			filt_avg15:
				y = avg - (avg >>> 4);
			default:
				y = avg - (avg >>> 3);  // 7/8 decay
		endcase
	end

endmodule

// File: noise_lfsr.sv
module noise_lfsr (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::sample_t seed,
	output ks_pkg::sample_t noise
);
	import ks_pkg::*;

	logic [23:0] lfsr_q;
	logic [23:0] lfsr_next;

	// galois step, feedback from bit 0 into the tap positions
	always_comb
	begin
		lfsr_next = {1'b0, lfsr_q[23:1]};
		if (lfsr_q[0])
			lfsr_next = lfsr_next ^ lfsr_taps;
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			if (seed == '0)
				lfsr_q <= 24'd1;  // all-zero state would lock up
			else
				lfsr_q <= seed;
		end
		else
			lfsr_q <= lfsr_next;
	end

	assign noise = sample_t'(lfsr_q);  // state read as two's complement

endmodule

// File: pluck_dispatch.sv
module pluck_dispatch (
	input logic a_clk,
	input logic reset_n,
	input logic trig,
	input ks_pkg::delay_len_t delay_length,
	output ks_pkg::pluck_cmd_t pluck [ks_pkg::num_voices]
);
	import ks_pkg::*;

	logic trig_sync_0;
	logic trig_sync_1;
	logic trig_now;  // accepted button level, 1 = pressed
	logic [$clog2(debounce_cycles)-1:0] stable_cnt;
	logic [$clog2(num_voices)-1:0] rr_ptr;
	logic trig_moved;
	logic accept;
	logic press;

	assign trig_moved = (trig_sync_1 != trig_now);
	assign accept = trig_moved && (stable_cnt == debounce_cycles - 1);
	assign press = accept && trig_sync_1;  // release is accepted but fires nothing

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			trig_sync_0 <= 1'b0;
			trig_sync_1 <= 1'b0;
			trig_now <= 1'b0;
			stable_cnt <= '0;
		end
		else
		begin
			trig_sync_0 <= ~trig;  // button pulls low
			trig_sync_1 <= trig_sync_0;
			if (!trig_moved || accept)
				stable_cnt <= '0;  // bounce restarts the count
			else
				stable_cnt <= stable_cnt + 1'b1;
			if (accept)
				trig_now <= trig_sync_1;
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			rr_ptr <= '0;
		else if (press)
			rr_ptr <= (rr_ptr == num_voices - 1) ? '0 : rr_ptr + 1'b1;
	end

	// registered commands, only the selected voice sees fire
	always_ff @(posedge a_clk)
	begin
		for (int i = 0; i < num_voices; i++)
		begin
			if (reset_n)
				pluck[i].fire <= 1'b0;
			else
				pluck[i].fire <= press && (rr_ptr == i);
			pluck[i].length <= delay_length;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_ks_synth \
	-f ks_synth.f -o tb_ks_synth || exit 1
result=$(./obj_dir/tb_ks_synth +verilator+error+limit+100 2>&1)
echo "$result"
echo "$result" | grep -q "^SIMULATION PASSED$" && exit 0 || exit 1

// File: string_voice.sv
module string_voice (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::pluck_cmd_t cmd,
	input ks_pkg::sample_t noise,
	input ks_pkg::filt_sel_t filt_sel,
	output ks_pkg::sample_t sample,
	output logic busy
);
	import ks_pkg::*;

	sample_t delay_mem [max_delay];
	voice_state_t state;
	delay_len_t len_q;  // latched string length
	delay_len_t pos;  // read and write share one position
	sample_t rd_data;
	sample_t filt_in;
	sample_t filt_out;
	sample_t wr_data;
	logic filt_clear;
	logic last_pos;

	assign rd_data = delay_mem[pos];  // value written len_q cycles ago
	assign last_pos = (pos == len_q - 1'b1);
	assign busy = (state != voice_idle);

	// feeding noise during excite leaves the filter history at the
	// last written entry, which precedes entry 0 around the loop
	assign filt_in = (state == voice_ring) ? rd_data : noise;
	assign wr_data = (state == voice_ring) ? filt_out : noise;
	assign filt_clear = reset_n || cmd.fire;

	loop_filter u_filt (
		.a_clk(a_clk),
		.reset_n(filt_clear),
		.filt_sel(filt_sel),
		.x(filt_in),
		.y(filt_out)
	);

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
		begin
			state <= voice_idle;
			len_q <= '0;
			pos <= '0;
		end
		else if (cmd.fire)
		begin
			state <= voice_excite;  // a new pluck restarts any voice
			len_q <= cmd.length;
			pos <= '0;
		end
		else
		begin
			case (state)
				voice_excite:
				begin
					pos <= last_pos ? '0 : pos + 1'b1;
					if (last_pos)
						state <= voice_ring;
				end
				voice_ring:
					pos <= last_pos ? '0 : pos + 1'b1;
				default:
					pos <= '0;
			endcase
		end
	end

	always_ff @(posedge a_clk)
	begin
		if (busy)
			delay_mem[pos] <= wr_data;
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			sample <= '0;
		else if (busy)
			sample <= wr_data;  // what went into the line this cycle
	end

endmodule

// File: tb_ks_synth.sv
module tb_ks_synth;
	import ks_pkg::*;

	localparam int clk_period = 40;
	localparam int reset_cycles = 5;
	localparam int press_cycles = 40;  // low time, release debounce, slack
	localparam int test_cycles = 10 * reset_cycles + 14 * press_cycles + 31 * max_delay;
	localparam int timeout_cycles = test_cycles + 500;

	logic a_clk;
	logic reset_n;
	sample_t seed_val;
	filt_sel_t filtsw;
	logic trig;
	delay_len_t delay_length;
	sample_t qout;
	logic [num_voices-1:0] voice_busy;

	logic [31:0] rng_state = 32'he5d1;
	int cycle_count = 0;

	ks_synth dut0 (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.seed_val(seed_val),
		.filtsw(filtsw),
		.trig(trig),
		.delay_length(delay_length),
		.qout(qout),
		.voice_busy(voice_busy)
	);

	bind ks_synth ks_synth_assertions u_asrt (
		.a_clk(a_clk),
		.reset_n(reset_n),
		.qout(qout),
		.voice_busy(voice_busy),
		.pluck(pluck)
	);

	initial
	begin
		a_clk = 1'b0;
		forever
			#(clk_period / 2) a_clk = ~a_clk;
	end

	always @(posedge a_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
		begin
			$display("SIMULATION FAILED");
			$fatal(1, "timeout, the tests did not finish within %0d cycles", timeout_cycles);
		end
		else if (dut0.u_asrt.fail_cnt != 0)
		begin
			$display("SIMULATION FAILED");
			$fatal(1, "a bound assertion on the DUT failed");
		end
	end

	// galois lfsr, one step per bit taken
	function automatic logic lfsr_bit();
		logic out;
		out = rng_state[0];
		rng_state = {1'b0, rng_state[31:1]};
		if (out)
			rng_state = rng_state ^ 32'h80200003;
		return out;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic int rand_length();
		return 8 + int'(random_bits(8) % 248);  // 8 to 255
	endfunction

	function automatic int abs_val(input sample_t v);
		if (v < 0)
			return -int'(v);
		return int'(v);
	endfunction

	task automatic check(input bit ok, input string what);
		assert (ok)
		else
		begin
			$display("FAIL %0t: %s", $time, what);
			$display("SIMULATION FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	task automatic apply_reset(input sample_t seed);
		reset_n = 1'b1;
		trig = 1'b1;
		seed_val = seed;
		repeat (reset_cycles) @(negedge a_clk);
		reset_n = 1'b0;
		check(qout == 0 && voice_busy == 0,
			$sformatf("after reset qout %0d busy %b, expected 0 and 0", qout, voice_busy));
	endtask

	// button pulls trig low, then release and let it settle
	task automatic press_trig(input int low_cycles);
		trig = 1'b0;
		repeat (low_cycles) @(negedge a_clk);
		trig = 1'b1;
		repeat (debounce_cycles + 8) @(negedge a_clk);
	endtask

	task automatic wait_busy(input logic [num_voices-1:0] mask);
		int n;
		n = 0;
		while (voice_busy !== mask && n < 32)
		begin
			@(negedge a_clk);
			n++;
		end
		check(voice_busy === mask, $sformatf("voice_busy %b, expected %b", voice_busy, mask));
	endtask

	task automatic idle_after_reset();
		apply_reset(sample_t'(random_bits(24)));
		repeat (20)
		begin
			@(negedge a_clk);
			check(qout == 0 && voice_busy == 0,
				$sformatf("idle qout %0d busy %b, expected 0 and 0", qout, voice_busy));
		end
	endtask

	task automatic short_glitch();
		apply_reset(sample_t'(random_bits(24)));
		press_trig(debounce_cycles - 1);  // one cycle short of acceptance
		repeat (20)
		begin
			check(voice_busy == 0, $sformatf("busy %b after a short glitch", voice_busy));
			@(negedge a_clk);
		end
	endtask

	task automatic round_robin_order();
		logic [num_voices-1:0] expected;
		delay_len_t first_len;
		apply_reset(sample_t'(random_bits(24)));
		filtsw = filt_avg;
		first_len = delay_len_t'(rand_length());
		delay_length = first_len;
		expected = '0;
		for (int v = 0; v < num_voices; v++)
		begin
			expected[v] = 1'b1;
			press_trig(10);
			wait_busy(expected);
		end
		delay_length = first_len ^ 8'd1;  // 8 to 255 maps onto itself
		press_trig(10);  // pointer wraps to voice 0
		wait_busy(expected);
		check(dut0.gen_voice[0].u_voice.len_q == delay_length
			&& dut0.gen_voice[1].u_voice.len_q == first_len,
			$sformatf("after the wrap press voice 0 length %0d, expected %0d",
			dut0.gen_voice[0].u_voice.len_q, delay_length));
	endtask

	task automatic lossless_period();
		sample_t hist[$];
		int len;
		bit nonzero;
		len = rand_length();
		apply_reset(sample_t'(random_bits(24)));
		filtsw = filt_bypass;
		delay_length = delay_len_t'(len);
		press_trig(10);
		wait_busy(num_voices'(1));
		repeat (len + 4) @(negedge a_clk);  // excitation over
		nonzero = 0;
		for (int k = 0; k < 4 * len; k++)
		begin
			hist.push_back(qout);
			if (qout != 0)
				nonzero = 1;
			if (k >= len)
				check(qout == hist[k - len],
					$sformatf("qout %0d, expected %0d from %0d cycles earlier",
					qout, hist[k - len], len));
			@(negedge a_clk);
		end
		check(nonzero, "qout stayed at zero on a plucked lossless string");
	endtask

	task automatic filtered_decay();
		int peak[$];
		int len;
		int cur;
		len = rand_length();
		apply_reset(sample_t'(random_bits(24)));
		filtsw = filt_avg7;
		delay_length = delay_len_t'(len);
		press_trig(10);
		wait_busy(num_voices'(1));
		repeat (5 * len + 4) @(negedge a_clk);  // a few smoothing passes
		for (int w = 0; w < 16; w++)
		begin
			cur = 0;
			for (int k = 0; k < len; k++)
			begin
				if (abs_val(qout) > cur)
					cur = abs_val(qout);
				@(negedge a_clk);
			end
			peak.push_back(cur);
			if (w > 0)
				check(cur <= peak[w - 1],
					$sformatf("window %0d peak %0d above previous %0d",
					w, cur, peak[w - 1]));
		end
		check(peak[0] > 0, "decaying string had no output in its first window");
		check(peak[15] < peak[0], $sformatf("last peak %0d, expected below first %0d",
			peak[15], peak[0]));
	endtask

	task automatic full_mix_saturation();
		int clamp_hits;
		apply_reset(sample_t'(random_bits(24)));
		filtsw = filt_bypass;
		for (int v = 0; v < num_voices; v++)
		begin
			delay_length = delay_len_t'(rand_length());
			press_trig(10);
		end
		wait_busy('1);
		clamp_hits = 0;
		for (int k = 0; k < 4 * max_delay; k++)
		begin
			check(!$isunknown(qout), $sformatf("qout %h has unknown bits", qout));
			if (qout == sample_max || qout == sample_min)
				clamp_hits++;  // full-scale noise on four voices overshoots often
			@(negedge a_clk);
		end
		check(clamp_hits > 0, "four full-scale voices never drove qout to a clamp limit");
		apply_reset(sample_t'(random_bits(24)));
	endtask

	initial
	begin
		reset_n = 1'b1;
		trig = 1'b1;
		seed_val = '0;
		filtsw = filt_bypass;
		delay_length = delay_len_t'(8);
		idle_after_reset();
		short_glitch();
		round_robin_order();
		lossless_period();
		filtered_decay();
		full_mix_saturation();
		if (dut0.u_asrt.fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: voice_mixer.sv
module voice_mixer (
	input logic a_clk,
	input logic reset_n,
	input ks_pkg::sample_t samples [ks_pkg::num_voices],
	output ks_pkg::sample_t mix
);
	import ks_pkg::*;

	logic signed [mix_width-1:0] sum;
	sample_t clamped;

	// widened sum, cannot wrap for num_voices inputs
	always_comb
	begin
		sum = '0;
		for (int i = 0; i < num_voices; i++)
			sum = sum + samples[i];
	end

	always_comb
	begin
		if (sum > sample_max)
			clamped = sample_max;
		else if (sum < sample_min)
			clamped = sample_min;
		else
			clamped = sum[$bits(sample_t)-1:0];
	end

	always_ff @(posedge a_clk)
	begin
		if (reset_n)
			mix <= '0;
		else
			mix <= clamped;
	end

endmodule
